/* bench/palu_clock_gen.sv */
/*
 * Testbench clock and reset
 * 40 ns clock, active-low reset held for the first 5 cycles
 */
`default_nettype none

module palu_clock_gen (
    output logic g_clk,
    output logic g_resetn
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk;
    end

    initial begin
        g_resetn = 1'b0;
        repeat (5) @(posedge g_clk);
        g_resetn <= 1'b1;  // Released on a rising edge
    end

endmodule

`default_nettype wire

/* bench/palu_tb.sv */
/*
 * Packed ALU testbench
 * Runs multiplies from the vector file over APB, checks results, status and stalls
 */
`default_nettype none

module palu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [2:0]  pw;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res_lo;
        logic [31:0] res_hi;
        logic        err;
    } test_t;

    logic                    g_clk;
    logic                    g_resetn;
    palu_regs_pkg::apb_req_t apb_req;
    palu_regs_pkg::apb_rsp_t apb_rsp;
    test_t                   tests[$];
    int                      errors = 0;
    int                      npass = 0;
    int                      nfail = 0;
    int                      cycles = 0;
    int                      limit = 0;
    logic [15:0]             lfsr = 16'd4970;

    palu_clock_gen clk_gen_i (
        .g_clk    (g_clk),
        .g_resetn (g_resetn)
    );

    palu_top dut_i (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        if (got !== exp) begin
            $display("error at %0t: %s expected %h, got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // One APB transfer; outputs sampled at the falling edge of the access phase
    task automatic apb_xfer(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr,
                            output int waits);
        @(posedge g_clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge g_clk);
        apb_req.penable <= 1'b1;
        waits = 0;
        @(negedge g_clk);
        while (!apb_rsp.pready) begin
            waits++;
            @(negedge g_clk);
        end
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(posedge g_clk);  // Completing edge
        apb_req <= '0;
    endtask

    task automatic idle_gap();
        logic [1:0] n;
        lfsr = lfsr_next(lfsr);
        n[0] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        n[1] = lfsr[0];
        repeat (n) @(posedge g_clk);
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            npass++;
            $display("%s: ok", name);
        end else begin
            nfail++;
            $display("%s: FAILED", name);
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f[6];
        fd = $fopen("bench/palu_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/palu_tests.txt");
            nfail++;
        end else begin
            while ($fgets(line, fd)) begin
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
                    if (n == 6)
                        tests.push_back('{f[0][2:0], f[1], f[2], f[3], f[4], f[5][0]});
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input test_t t, input int idx);
        int          lw;
        int          err0;
        int          waits;
        int          polls;
        logic [31:0] rd;
        logic        serr;
        lw   = 32 >> t.pw;  // Lane width is also the multiply length in cycles
        err0 = errors;
        idle_gap();
        apb_xfer(1'b1, palu_regs_pkg::ADDR_OPA, t.a, rd, serr, waits);
        apb_xfer(1'b1, palu_regs_pkg::ADDR_OPB, t.b, rd, serr, waits);
        apb_xfer(1'b1, palu_regs_pkg::ADDR_CTRL,
                 (32'd1 << palu_regs_pkg::CTRL_START_BIT) | 32'(t.pw), rd, serr, waits);
        check_value("pslverr", 32'(t.err), 32'(serr));
        apb_xfer(1'b0, palu_regs_pkg::ADDR_STATUS, '0, rd, serr, waits);
        if (t.err) begin
            check_value("STATUS.busy", '0, 32'(rd[palu_regs_pkg::STATUS_BUSY_BIT]));
        end else begin
            if (lw >= 4)
                check_value("STATUS", 32'h1, rd);  // Busy with DONE cleared by start
            apb_xfer(1'b1, palu_regs_pkg::ADDR_OPA, ~t.a, rd, serr, waits);
            if (lw >= 8 && waits == 0) begin
                $display("OPA write at %0t went through during a multiply", $time);
                errors++;
            end
            polls = 0;
            do begin
                apb_xfer(1'b0, palu_regs_pkg::ADDR_STATUS, '0, rd, serr, waits);
                polls++;
            end while (!rd[palu_regs_pkg::STATUS_DONE_BIT]);
            if (lw >= 8 && polls != 1) begin
                $display("OPA write completed before the multiply finished at %0t", $time);
                errors++;
            end
            check_value("STATUS", 32'h2, rd);
            apb_xfer(1'b0, palu_regs_pkg::ADDR_RES_LO, '0, rd, serr, waits);
            check_value("RES_LO", t.res_lo, rd);
            apb_xfer(1'b0, palu_regs_pkg::ADDR_RES_HI, '0, rd, serr, waits);
            check_value("RES_HI", t.res_hi, rd);
            apb_xfer(1'b0, palu_regs_pkg::ADDR_OPA, '0, rd, serr, waits);
            check_value("OPA", ~t.a, rd);
        end
        report_test($sformatf("test %0d pw %0d", idx, t.pw), err0);
    endtask

    always @(posedge g_clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("run stopped after %0d cycles without finishing", limit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int          err0;
        int          waits;
        logic [31:0] rd;
        logic        serr;
        apb_req = '0;
        load_tests();
        limit = tests.size() * 60 + 100;
        if (tests.size() == 0)
            nfail++;
        @(posedge g_resetn);
        err0 = errors;
        for (int addr = 0; addr <= 'h14; addr += 4) begin
            apb_xfer(1'b0, 5'(addr), '0, rd, serr, waits);
            check_value($sformatf("reg 0x%02h", addr), '0, rd);
        end
        apb_xfer(1'b0, 5'h18, '0, rd, serr, waits);  // Unmapped
        check_value("pslverr", 32'h1, 32'(serr));
        report_test("reset state", err0);
        foreach (tests[i])
            run_test(tests[i], i);
        $display("%0d tests passed, %0d failed", npass, nfail);
        if (nfail == 0 && errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/palu_tests.txt */
# Hex columns: pw a b res_lo res_hi err
# err=1 means the CTRL write must return pslverr and start nothing
0 ffffffff ffffffff 00000001 fffffffe 0
0 00010000 00010000 00000000 00000001 0
0 80000000 00000003 80000000 00000001 0
0 deadbeef 00000002 bd5b7dde 00000001 0
0 0000ffff 0000ffff fffe0001 00000000 0
1 ffff0003 ffff0005 0001000f 00000000 0
1 12340100 00100100 23400000 00000000 0
1 ffffffff ffffffff 00010001 00000000 0
2 ff100203 ff100405 0100080f 00000000 0
3 fedcba98 11111111 fedcba98 00000000 0
3 22222222 33333333 66666666 00000000 0
3 ffffffff ffffffff 11111111 00000000 0
4 ffffffff ffffffff 55555555 00000000 0
4 aaaaaaaa aaaaaaaa 00000000 00000000 0
4 ffffffff aaaaaaaa aaaaaaaa 00000000 0
5 00000003 00000005 00000000 00000000 1
6 00000003 00000005 00000000 00000000 1
7 00000003 00000005 00000000 00000000 1

/* flist.f */
hdl/palu_pkg.sv
hdl/palu_regs_pkg.sv
hdl/palu_packed_shifter.sv
hdl/palu_packed_adder.sv
hdl/palu_multiplier.sv
hdl/palu_reg_block.sv
hdl/palu_top.sv
bench/palu_clock_gen.sv
bench/palu_tb.sv

/* hdl/palu_multiplier.sv */
/*
 * Packed shift-and-add multiplier
 * One bit of each lane of b per cycle, using the external shifter and adder
 */
`default_nettype none

module palu_multiplier (
    input  logic                         g_clk,
    input  logic                         g_resetn,
    input  logic                         run,
    input  palu_pkg::mul_req_t           mul_req,
    output palu_pkg::mul_rsp_t           mul_rsp,
    output logic [palu_pkg::XLEN-1:0]    shf_a,
    output logic [palu_pkg::SHAMT_W-1:0] shf_sham,
    input  logic [palu_pkg::XLEN-1:0]    shf_c,
    output logic [palu_pkg::RLEN-1:0]    add_a,
    output logic [palu_pkg::RLEN-1:0]    add_b,
    input  logic [palu_pkg::RLEN-1:0]    add_c
);

    logic [palu_pkg::SHAMT_W-1:0] ctr;       // Step count and bit index in each lane
    logic [palu_pkg::SHAMT_W-1:0] ctr_stop;
    logic [palu_pkg::XLEN-1:0]    add_mask;
    logic [palu_pkg::XLEN-1:0]    spill;
    logic [palu_pkg::RLEN-1:0]    acc;
    logic                         pw_1;
    logic                         done;

    assign ctr_stop = palu_pkg::lane_top(mul_req.pw);
    assign pw_1     = mul_req.pw == palu_pkg::PW_1;
    assign done     = run && ctr == ctr_stop;

    // Bit ctr of each lane of b spread over that lane
    always_comb begin
        for (int i = 0; i < palu_pkg::XLEN; i++) begin
            add_mask[i] = mul_req.b[(5'(i) & ~ctr_stop) | ctr];
        end
    end

    // Full-width mode keeps the bits of a pushed past bit 31
    assign spill = (pw_1 && ctr != '0) ? mul_req.a >> (palu_pkg::XLEN - ctr) : '0;

    assign shf_a    = mul_req.a;
    assign shf_sham = ctr;

    assign add_a = {spill & add_mask, shf_c & add_mask};
    assign add_b = (ctr == '0) ? '0 : acc;  // First step starts from zero

    always_ff @(posedge g_clk) begin
        if (run)
            acc <= add_c;
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            ctr <= '0;
        end else if (done) begin
            ctr <= '0;
        end else if (run) begin
            ctr <= ctr + 1'b1;
        end
    end

    assign mul_rsp.done   = done;
    assign mul_rsp.result = add_c;  // Last partial sum completes the product

    a_ctr_bound: assert property (@(posedge g_clk) disable iff (!g_resetn)
        ctr <= ctr_stop);

    // Register block must drop run right after done
    a_done_run: assert property (@(posedge g_clk) disable iff (!g_resetn)
        done |=> !run);

endmodule

`default_nettype wire

/* hdl/palu_packed_adder.sv */
/*
 * Packed adder
 * 64-bit ripple adder with the carry cut at lane edges in the low word
 */
`default_nettype none

module palu_packed_adder (
    input  logic [palu_pkg::RLEN-1:0] add_a,
    input  logic [palu_pkg::RLEN-1:0] add_b,
    input  palu_pkg::pw_t             pw,
    output logic [palu_pkg::RLEN-1:0] add_c
);

    logic [palu_pkg::SHAMT_W-1:0] lw_m1;
    logic [palu_pkg::RLEN-1:0]    cut;
    logic                         full;

    assign lw_m1 = palu_pkg::lane_top(pw);
    assign full  = pw == palu_pkg::PW_1;  // One lane, carry into the high word

    // Top bit of each lane below bit 32 ends the chain
    always_comb begin
        cut = '0;
        for (int i = 0; i < palu_pkg::XLEN; i++) begin
            cut[i] = !full && ((5'(i) & lw_m1) == lw_m1);
        end
    end

    always_comb begin : ripple
        logic carry;
        carry = 1'b0;
        for (int i = 0; i < palu_pkg::RLEN; i++) begin
            add_c[i] = add_a[i] ^ add_b[i] ^ carry;
            carry    = (add_a[i] && add_b[i]) || (carry && (add_a[i] ^ add_b[i]));
            if (cut[i])
                carry = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/palu_packed_shifter.sv */
/*
 * Packed left shifter
 * Shifts every lane by the same amount, dropping bits at each lane edge
 */
`default_nettype none

module palu_packed_shifter (
    input  logic [palu_pkg::XLEN-1:0]    shf_a,
    input  logic [palu_pkg::SHAMT_W-1:0] shf_sham,
    input  palu_pkg::pw_t                pw,
    output logic [palu_pkg::XLEN-1:0]    shf_c
);

    logic [palu_pkg::SHAMT_W-1:0] lw_m1;
    logic [palu_pkg::SHAMT_W-1:0] sham;
    logic [palu_pkg::XLEN-1:0]    raw;

    assign lw_m1 = palu_pkg::lane_top(pw);
    assign sham  = shf_sham & lw_m1;  // Amount modulo lane width
    assign raw   = shf_a << sham;

    // Bits whose offset in the lane is below the shift came from the lane beneath
    always_comb begin
        for (int i = 0; i < palu_pkg::XLEN; i++) begin
            shf_c[i] = raw[i] && ((5'(i) & lw_m1) >= sham);
        end
    end

endmodule

`default_nettype wire

/* hdl/palu_pkg.sv */
/*
 * Packed ALU datapath definitions
 * Pack-width codes, lane geometry and the multiply request/response structs
 */
`default_nettype none

package palu_pkg;

    localparam int XLEN    = 32;   // Operand width
    localparam int RLEN    = 64;   // Result width
    localparam int SHAMT_W = 5;    // Shift amount / bit index width

    typedef logic [2:0] pw_t;

    // Pack-width codes, lane count in the name
    localparam pw_t PW_1  = 3'd0;  // 1 x 32-bit
    localparam pw_t PW_2  = 3'd1;  // 2 x 16-bit
    localparam pw_t PW_4  = 3'd2;  // 4 x 8-bit
    localparam pw_t PW_8  = 3'd3;  // 8 x 4-bit
    localparam pw_t PW_16 = 3'd4;  // 16 x 2-bit

    typedef struct packed {
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        pw_t             pw;
    } mul_req_t;

    typedef struct packed {
        logic            done;
        logic [RLEN-1:0] result;
    } mul_rsp_t;

    // Lane width minus one, also the bit index mask within a lane
    function automatic logic [SHAMT_W-1:0] lane_top(input pw_t pw);
        case (pw)
            PW_2:    return 5'd15;
            PW_4:    return 5'd7;
            PW_8:    return 5'd3;
            PW_16:   return 5'd1;
            default: return 5'd31;  // PW_1
        endcase
    endfunction

    function automatic logic pw_legal(input pw_t pw);
        return pw <= PW_16;
    endfunction

endpackage

`default_nettype wire

/* hdl/palu_reg_block.sv */
/*
 * Packed ALU register block
 * APB slave for operands, pack width, status and result; starts the multiplier
 */
`default_nettype none

module palu_reg_block (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  palu_regs_pkg::apb_req_t apb_req,
    output palu_regs_pkg::apb_rsp_t apb_rsp,
    output palu_pkg::mul_req_t      mul_req,
    output logic                    run,
    input  palu_pkg::mul_rsp_t      mul_rsp
);

    logic [palu_pkg::XLEN-1:0] opa;
    logic [palu_pkg::XLEN-1:0] opb;
    palu_pkg::pw_t             pw;
    logic                      busy;
    logic                      done_flag;
    logic [palu_pkg::RLEN-1:0] res;

    logic                      access;
    logic                      is_ctrl;
    logic                      unmapped;
    logic                      pw_bad;
    logic                      stall;
    logic                      err;
    logic                      wr_ok;
    logic                      start;
    palu_pkg::pw_t             wr_pw;
    logic [palu_pkg::XLEN-1:0] rdata;

    assign access  = apb_req.psel && apb_req.penable;
    assign is_ctrl = apb_req.paddr == palu_regs_pkg::ADDR_CTRL;
    assign wr_pw   = apb_req.pwdata[palu_regs_pkg::CTRL_PW_LSB +: $bits(palu_pkg::pw_t)];

    // Read mux and address decode
    always_comb begin
        rdata    = '0;
        unmapped = 1'b0;
        case (apb_req.paddr)
            palu_regs_pkg::ADDR_OPA:    rdata = opa;
            palu_regs_pkg::ADDR_OPB:    rdata = opb;
            palu_regs_pkg::ADDR_CTRL:   rdata[palu_regs_pkg::CTRL_PW_LSB +: 3] = pw;
            palu_regs_pkg::ADDR_STATUS: begin
                rdata[palu_regs_pkg::STATUS_BUSY_BIT] = busy;
                rdata[palu_regs_pkg::STATUS_DONE_BIT] = done_flag;
            end
            palu_regs_pkg::ADDR_RES_LO: rdata = res[palu_pkg::XLEN-1:0];
            palu_regs_pkg::ADDR_RES_HI: rdata = res[palu_pkg::RLEN-1:palu_pkg::XLEN];
            default:                    unmapped = 1'b1;
        endcase
    end

    // Operand and control writes wait out a running multiply
    assign stall = access && apb_req.pwrite && busy &&
                   (apb_req.paddr == palu_regs_pkg::ADDR_OPA ||
                    apb_req.paddr == palu_regs_pkg::ADDR_OPB || is_ctrl);

    assign pw_bad = apb_req.pwrite && is_ctrl && !palu_pkg::pw_legal(wr_pw);
    assign err    = access && (unmapped || pw_bad);
    assign wr_ok  = access && apb_req.pwrite && !stall && !err;
    assign start  = wr_ok && is_ctrl && apb_req.pwdata[palu_regs_pkg::CTRL_START_BIT];

    assign apb_rsp.pready  = !stall;
    assign apb_rsp.pslverr = err && !stall;  // Only in the completing cycle
    assign apb_rsp.prdata  = rdata;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            opa       <= '0;
            opb       <= '0;
            pw        <= palu_pkg::PW_1;
            busy      <= 1'b0;
            done_flag <= 1'b0;
            res       <= '0;
        end else begin
            if (wr_ok && apb_req.paddr == palu_regs_pkg::ADDR_OPA)
                opa <= apb_req.pwdata;
            if (wr_ok && apb_req.paddr == palu_regs_pkg::ADDR_OPB)
                opb <= apb_req.pwdata;
            if (wr_ok && is_ctrl)
                pw <= wr_pw;
            if (start) begin
                busy      <= 1'b1;
                done_flag <= 1'b0;
            end else if (mul_rsp.done) begin
                busy      <= 1'b0;
                done_flag <= 1'b1;
                res       <= mul_rsp.result;  // Final sum is valid in the done cycle
            end
        end
    end

    assign run = busy;

    assign mul_req.a  = opa;
    assign mul_req.b  = opb;
    assign mul_req.pw = pw;

    // Multiplier must only finish a multiply that was asked for
    a_done_in_run: assert property (@(posedge g_clk) disable iff (!g_resetn)
        mul_rsp.done |-> run);

endmodule

`default_nettype wire

/* hdl/palu_regs_pkg.sv */
/*
 * Packed ALU register map
 * APB offsets, CTRL/STATUS field positions and the APB request/response structs
 */
`default_nettype none

package palu_regs_pkg;

    localparam int ADDR_W = 5;

    localparam logic [ADDR_W-1:0] ADDR_OPA    = 5'h00;
    localparam logic [ADDR_W-1:0] ADDR_OPB    = 5'h04;
    localparam logic [ADDR_W-1:0] ADDR_CTRL   = 5'h08;
    localparam logic [ADDR_W-1:0] ADDR_STATUS = 5'h0C;
    localparam logic [ADDR_W-1:0] ADDR_RES_LO = 5'h10;
    localparam logic [ADDR_W-1:0] ADDR_RES_HI = 5'h14;

    // CTRL fields
    localparam int CTRL_PW_LSB    = 0;  // pw code in [2:0]
    localparam int CTRL_START_BIT = 8;  // Write-only, reads as zero

    // STATUS fields
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;  // Sticky until next start

    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [ADDR_W-1:0]         paddr;
        logic [palu_pkg::XLEN-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic                      pready;
        logic                      pslverr;
        logic [palu_pkg::XLEN-1:0] prdata;
    } apb_rsp_t;

endpackage

`default_nettype wire

/* hdl/palu_top.sv */
/*
 * Packed ALU multiply slice
 * APB register block driving a multiplier with shared shifter and adder
 */
`default_nettype none

module palu_top (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  palu_regs_pkg::apb_req_t apb_req,
    output palu_regs_pkg::apb_rsp_t apb_rsp
);

    palu_pkg::mul_req_t           mul_req;
    palu_pkg::mul_rsp_t           mul_rsp;
    logic                         run;
    logic [palu_pkg::XLEN-1:0]    shf_a;
    logic [palu_pkg::SHAMT_W-1:0] shf_sham;
    logic [palu_pkg::XLEN-1:0]    shf_c;
    logic [palu_pkg::RLEN-1:0]    add_a;
    logic [palu_pkg::RLEN-1:0]    add_b;
    logic [palu_pkg::RLEN-1:0]    add_c;

    palu_reg_block reg_block_i (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .mul_req  (mul_req),
        .run      (run),
        .mul_rsp  (mul_rsp)
    );

    palu_multiplier multiplier_i (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .run      (run),
        .mul_req  (mul_req),
        .mul_rsp  (mul_rsp),
        .shf_a    (shf_a),
        .shf_sham (shf_sham),
        .shf_c    (shf_c),
        .add_a    (add_a),
        .add_b    (add_b),
        .add_c    (add_c)
    );

    palu_packed_shifter shifter_i (
        .shf_a    (shf_a),
        .shf_sham (shf_sham),
        .pw       (mul_req.pw),
        .shf_c    (shf_c)
    );

    palu_packed_adder adder_i (
        .add_a    (add_a),
        .add_b    (add_b),
        .pw       (mul_req.pw),
        .add_c    (add_c)
    );

endmodule

`default_nettype wire
